//--- design/apbRegPkg.sv
/*
 * Register map and field layout of the APB side of the I2C master.
 * Imported by the register block, the engine and the top level for the
 * divider width, and by the testbench for offsets and status bits.
 */
`default_nettype none

package apbRegPkg;

	// Register offsets on the APB bus
	localparam logic [31:0] ADDR_TX   = 32'd0;
	localparam logic [31:0] ADDR_RX   = 32'd4;
	localparam logic [31:0] ADDR_CFG  = 32'd8;
	localparam logic [31:0] ADDR_STAT = 32'd12;

	// Status register bit positions
	localparam int STAT_TX_EMPTY = 0;
	localparam int STAT_TX_FULL  = 1;
	localparam int STAT_RX_EMPTY = 2;
	localparam int STAT_BUSY     = 3;
	localparam int STAT_ACK_ERR  = 4;
	localparam int STAT_W        = 5;

	// Command layout inside PWDATA on a TX write
	localparam int CMD_DATA_LSB   = 0;
	localparam int CMD_DATA_MSB   = 7;
	localparam int CMD_READ_BIT   = 8;
	localparam int CMD_START_BIT  = 9;
	localparam int CMD_STOP_BIT   = 10;
	localparam int CMD_ACKOUT_BIT = 11;

	// RX read word, ack returned by the target sits above the byte
	localparam int RX_ACK_BIT = 8;

	// Clock divider field of the configuration register
	localparam int DIV_W = 14;

endpackage

`default_nettype wire

//--- design/i2cPkg.sv
/*
 * Types of the I2C side: byte command, receive entry and bus phases.
 * Shared by the register block, both FIFO instances and the engine.
 */
`default_nettype none

package i2cPkg;

	// One byte command as queued in the command FIFO
	typedef struct packed {
		logic       start;
		logic       stop;
		logic       read;
		// Ack driven by the master after a read byte, 1 means nack
		logic       ackOut;
		// Sent on writes, ignored on reads
		logic [7:0] data;
	} i2cCmd_t;

	// Result of one completed command
	typedef struct packed {
		// Target ack on writes, 1 means nack, always 0 on reads
		logic       ack;
		logic [7:0] data;
	} i2cRx_t;

	// Bus phases of the bit sequencer
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_START,
		PH_BIT,
		PH_ACK,
		PH_STOP
	} i2cPhase_e;

endpackage

`default_nettype wire

//--- design/i2cFifo.sv
/*
 * Synchronous FIFO with valid/ready on both sides.
 * The entry type is a parameter, so one module buffers commands and
 * received bytes. A push is visible at the output one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module i2cFifo #(
	parameter type         entry_t    = logic [7:0],
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  wire logic   PCLK,
	input  wire logic   PRESETn,
	input  wire logic   inValid,
	input  wire entry_t inData,
	output logic        inReady,
	output logic        outValid,
	output entry_t      outData,
	input  wire logic   outReady,
	output logic        empty,
	output logic        full
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	entry_t             mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wrPtr;
	logic [PTR_W-1:0]   rdPtr;
	logic [CNT_W-1:0]   count;
	logic               push;
	logic               pop;

	// Flags straight from the occupancy count
	assign empty    = (count == '0);
	assign full     = (count == CNT_W'(FIFO_DEPTH));
	assign inReady  = !full;
	assign outValid = !empty;
	assign outData  = mem[rdPtr];

	assign push = inValid && inReady;
	assign pop  = outValid && outReady;

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (push)
			mem[wrPtr] <= inData;
	end

	// Pointers wrap at the depth, which need not be a power of two
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			// Push and pop together keep the count
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Empty and full both leave the write pointer on the read pointer
	ptrsMeetAtEnds: assert property (@(posedge PCLK) disable iff (!PRESETn)
		empty || full |-> wrPtr == rdPtr);

	// Any other occupancy keeps the pointers apart
	ptrsApartInBetween: assert property (@(posedge PCLK) disable iff (!PRESETn)
		wrPtr == rdPtr |-> empty || full);

endmodule

`default_nettype wire

//--- design/apbI2cRegs.sv
/*
 * Zero-wait APB slave of the I2C master.
 * TX writes become queued byte commands, RX reads pop the receive FIFO,
 * CFG holds the clock divider and STAT reports FIFO and engine state.
 */
`timescale 1ns/1ps
`default_nettype none

module apbI2cRegs
	import apbRegPkg::*, i2cPkg::*;
#(
	parameter int unsigned DIV_RESET = 4
) (
	input  wire logic              PCLK,
	input  wire logic              PRESETn,
	input  wire logic              PSEL,
	input  wire logic              PENABLE,
	input  wire logic              PWRITE,
	input  wire logic [31:0]       PADDR,
	input  wire logic [31:0]       PWDATA,
	output logic      [31:0]       PRDATA,
	output logic                   PREADY,
	output logic                   PSLVERR,
	// Command FIFO push side
	output logic                   cmdValid,
	output i2cCmd_t                cmdData,
	input  wire logic              cmdReady,
	// Receive FIFO pop side
	input  wire logic              rxHeadValid,
	input  wire i2cRx_t            rxHead,
	output logic                   rxPopReady,
	// Engine and FIFO status
	input  wire logic              engineBusy,
	input  wire logic              txEmpty,
	output logic      [DIV_W-1:0]  clkDiv,
	// Status level interrupts
	output logic                   intTx,
	output logic                   intRx
);

	logic              access;
	logic              txWrite;
	logic              rxRead;
	logic              cfgWrite;
	logic              statWrite;
	logic              ackErr;
	logic [STAT_W-1:0] status;

	//////////////////////////////////////////////////////////////////////
	// Access decode
	//////////////////////////////////////////////////////////////////////

	// Second cycle of a transfer
	assign access    = PSEL && PENABLE;
	assign txWrite   = access && PWRITE && (PADDR == ADDR_TX);
	assign rxRead    = access && !PWRITE && (PADDR == ADDR_RX);
	assign cfgWrite  = access && PWRITE && (PADDR == ADDR_CFG);
	assign statWrite = access && PWRITE && (PADDR == ADDR_STAT);

	// No wait states
	assign PREADY = access;

	// Full command FIFO or empty receive FIFO
	assign PSLVERR = (txWrite && !cmdReady) || (rxRead && !rxHeadValid);

	// Push only when there is room, so the command is taken on this edge
	assign cmdValid       = txWrite && cmdReady;
	assign cmdData.data   = PWDATA[CMD_DATA_MSB:CMD_DATA_LSB];
	assign cmdData.read   = PWDATA[CMD_READ_BIT];
	assign cmdData.start  = PWDATA[CMD_START_BIT];
	assign cmdData.stop   = PWDATA[CMD_STOP_BIT];
	assign cmdData.ackOut = PWDATA[CMD_ACKOUT_BIT];

	// Pop the head on the access edge
	assign rxPopReady = rxRead && rxHeadValid;

	//////////////////////////////////////////////////////////////////////
	// Read data
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		status                = '0;
		status[STAT_TX_EMPTY] = txEmpty;
		status[STAT_TX_FULL]  = !cmdReady;
		status[STAT_RX_EMPTY] = !rxHeadValid;
		status[STAT_BUSY]     = engineBusy;
		status[STAT_ACK_ERR]  = ackErr;
	end

	always_comb
	begin
		PRDATA = '0;
		case (PADDR)
			ADDR_RX:
			begin
				// Empty FIFO reads as zero
				if (rxHeadValid)
				begin
					PRDATA[7:0]        = rxHead.data;
					PRDATA[RX_ACK_BIT] = rxHead.ack;
				end
			end
			ADDR_CFG:
				PRDATA[DIV_W-1:0] = clkDiv;
			ADDR_STAT:
				PRDATA[STAT_W-1:0] = status;
			default:
				PRDATA = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Configuration and sticky error
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			clkDiv <= DIV_W'(DIV_RESET);
			ackErr <= 1'b0;
		end
		else
		begin
			if (cfgWrite)
				clkDiv <= PWDATA[DIV_W-1:0];
			// Nack seen by the host on a popped write entry
			if (rxPopReady && rxHead.ack)
				ackErr <= 1'b1;
			else if (statWrite)
				ackErr <= 1'b0;
		end
	end

	// TX done when nothing queued and the engine has finished
	assign intTx = txEmpty && !engineBusy;
	assign intRx = rxHeadValid;

	// Error response only in an access cycle that follows its setup cycle
	slvErrInAccess: assert property (@(posedge PCLK) disable iff (!PRESETn)
		PSLVERR |-> PSEL && PENABLE && $past(PSEL && !PENABLE));

	// One TX transfer queues at most one command
	onePushPerTransfer: assert property (@(posedge PCLK) disable iff (!PRESETn)
		cmdValid |=> !cmdValid);

endmodule

`default_nettype wire

//--- design/i2cMasterEngine.sv
/*
 * Bit-level I2C master: runs one byte command at a time on open-drain pads.
 * Each bit is four quarters of clkDiv+1 cycles. A command gives an optional
 * start, eight bits MSB first, an ack bit and an optional stop, then one
 * receive entry. Pad enables pull the line low when high.
 */
`timescale 1ns/1ps
`default_nettype none

module i2cMasterEngine
	import apbRegPkg::*, i2cPkg::*;
(
	input  wire logic             PCLK,
	input  wire logic             PRESETn,
	input  wire logic [DIV_W-1:0] clkDiv,
	// Command in
	input  wire logic             cmdValid,
	input  wire i2cCmd_t          cmd,
	output logic                  cmdReady,
	// Result out
	output logic                  rxValid,
	output i2cRx_t                rxData,
	input  wire logic             rxReady,
	output logic                  busy,
	// Pads
	output logic                  sclOe,
	output logic                  sdaOe,
	input  wire logic             sclIn,
	input  wire logic             sdaIn
);

	i2cPhase_e        phase;
	logic [DIV_W-1:0] divCnt;
	logic [1:0]       qCnt;
	logic [2:0]       bitCnt;
	logic             busOwned;
	logic             tick;
	logic             canAccept;
	logic             lastQuarter;
	i2cCmd_t          cmdReg;
	logic [7:0]       shiftReg;
	logic             ackBit;

	//////////////////////////////////////////////////////////////////////
	// Handshakes and quarter tick
	//////////////////////////////////////////////////////////////////////

	// Next command only after the last result is handed over and
	// the receive FIFO has room for the new one
	assign canAccept = (phase == PH_IDLE) && !rxValid && rxReady;
	assign cmdReady  = cmdValid && canAccept;
	assign busy      = (phase != PH_IDLE) || rxValid;

	// >= so a divider lowered mid-bit cannot run the counter round
	assign tick        = (phase != PH_IDLE) && (divCnt >= clkDiv);
	assign lastQuarter = tick && (qCnt == 2'd3);

	//////////////////////////////////////////////////////////////////////
	// Phase FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			phase    <= PH_IDLE;
			divCnt   <= '0;
			qCnt     <= '0;
			bitCnt   <= '0;
			busOwned <= 1'b0;
			rxValid  <= 1'b0;
		end
		else
		begin
			if (rxValid && rxReady)
				rxValid <= 1'b0;
			if (phase == PH_IDLE)
			begin
				if (cmdReady)
				begin
					phase  <= cmd.start ? PH_START : PH_BIT;
					divCnt <= '0;
					qCnt   <= '0;
					bitCnt <= 3'd7;
				end
			end
			else if (!tick)
				divCnt <= divCnt + 1'b1;
			else
			begin
				divCnt <= '0;
				qCnt   <= qCnt + 1'b1;
				if (qCnt == 2'd3)
				begin
					case (phase)
						PH_START:
						begin
							phase    <= PH_BIT;
							busOwned <= 1'b1;
						end
						PH_BIT:
						begin
							if (bitCnt == 3'd0)
								phase <= PH_ACK;
							else
								bitCnt <= bitCnt - 1'b1;
						end
						PH_ACK:
						begin
							// Without stop the bus stays owned, SCL held low
							if (cmdReg.stop)
								phase <= PH_STOP;
							else
							begin
								phase   <= PH_IDLE;
								rxValid <= 1'b1;
							end
						end
						PH_STOP:
						begin
							phase    <= PH_IDLE;
							busOwned <= 1'b0;
							rxValid  <= 1'b1;
						end
						default:
							phase <= PH_IDLE;
					endcase
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (cmdReady)
		begin
			cmdReg   <= cmd;
			shiftReg <= cmd.data;
		end
		else if (tick && phase == PH_BIT)
		begin
			// Reads sample at the end of the SCL rising quarter
			if (cmdReg.read && qCnt == 2'd1)
				shiftReg <= {shiftReg[6:0], sdaIn};
			// Writes move to the next bit while SCL is low
			else if (!cmdReg.read && qCnt == 2'd3)
				shiftReg <= {shiftReg[6:0], 1'b0};
		end
		// Target ack, high means nack
		if (tick && phase == PH_ACK && qCnt == 2'd1)
			ackBit <= sdaIn;
		if (lastQuarter && phase == PH_ACK)
		begin
			rxData.data <= cmdReg.read ? shiftReg : cmdReg.data;
			rxData.ack  <= cmdReg.read ? 1'b0 : ackBit;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pad drive
	//////////////////////////////////////////////////////////////////////

	// SCL low in quarters 0 and 3, high in 1 and 2
	always_comb
	begin
		sclOe = 1'b0;
		sdaOe = 1'b0;
		case (phase)
			PH_IDLE:
				sclOe = busOwned;
			PH_START:
			begin
				// Repeated start first lets SDA up while SCL is still low
				sclOe = (qCnt == 2'd0) ? busOwned : (qCnt == 2'd3);
				// SDA falls in quarter 2 with SCL high
				sdaOe = (qCnt >= 2'd2);
			end
			PH_BIT:
			begin
				sclOe = (qCnt == 2'd0) || (qCnt == 2'd3);
				sdaOe = !cmdReg.read && !shiftReg[7];
			end
			PH_ACK:
			begin
				sclOe = (qCnt == 2'd0) || (qCnt == 2'd3);
				// Master acks a read byte unless ackOut asks for nack
				sdaOe = cmdReg.read && !cmdReg.ackOut;
			end
			PH_STOP:
			begin
				sclOe = (qCnt == 2'd0);
				// SDA rises in quarter 2 with SCL high
				sdaOe = (qCnt <= 2'd1);
			end
			default:
			begin
				sclOe = 1'b0;
				sdaOe = 1'b0;
			end
		endcase
	end

	// Outside start and stop, SDA only moves while the SCL line is low
	sdaStableOnSclHigh: assert property (@(posedge PCLK) disable iff (!PRESETn)
		$changed(sdaOe) && !(phase inside {PH_START, PH_STOP})
			&& !($past(phase) inside {PH_START, PH_STOP})
		|-> !sclIn && !$past(sclIn));

endmodule

`default_nettype wire

//--- design/apbI2cTop.sv
/*
 * APB-attached I2C master top level.
 * Register block feeds a command FIFO, the engine drains it and returns
 * results through a receive FIFO. Pads are open-drain enables.
 */
`timescale 1ns/1ps
`default_nettype none

module apbI2cTop
	import apbRegPkg::*, i2cPkg::*;
#(
	parameter int unsigned FIFO_DEPTH = 4,
	parameter int unsigned DIV_RESET  = 4
) (
	input  wire logic        PCLK,
	input  wire logic        PRESETn,
	input  wire logic        PSEL,
	input  wire logic        PENABLE,
	input  wire logic        PWRITE,
	input  wire logic [31:0] PADDR,
	input  wire logic [31:0] PWDATA,
	output logic      [31:0] PRDATA,
	output logic             PREADY,
	output logic             PSLVERR,
	output logic             intTx,
	output logic             intRx,
	output logic             sclOe,
	output logic             sdaOe,
	input  wire logic        sclIn,
	input  wire logic        sdaIn
);

	// Register block to command FIFO
	logic             cmdValid;
	i2cCmd_t          cmdData;
	logic             cmdReady;
	// Command FIFO to engine
	logic             cmdOutValid;
	i2cCmd_t          cmdOut;
	logic             cmdOutReady;
	// Engine to receive FIFO
	logic             rxValid;
	i2cRx_t           rxData;
	logic             rxReady;
	// Receive FIFO to register block
	logic             rxHeadValid;
	i2cRx_t           rxHead;
	logic             rxPopReady;
	// Status and configuration
	logic             txEmpty;
	logic             engineBusy;
	logic [DIV_W-1:0] clkDiv;

	apbI2cRegs #(
		.DIV_RESET (DIV_RESET)
	) uRegs (
		.PCLK        (PCLK),
		.PRESETn     (PRESETn),
		.PSEL        (PSEL),
		.PENABLE     (PENABLE),
		.PWRITE      (PWRITE),
		.PADDR       (PADDR),
		.PWDATA      (PWDATA),
		.PRDATA      (PRDATA),
		.PREADY      (PREADY),
		.PSLVERR     (PSLVERR),
		.cmdValid    (cmdValid),
		.cmdData     (cmdData),
		.cmdReady    (cmdReady),
		.rxHeadValid (rxHeadValid),
		.rxHead      (rxHead),
		.rxPopReady  (rxPopReady),
		.engineBusy  (engineBusy),
		.txEmpty     (txEmpty),
		.clkDiv      (clkDiv),
		.intTx       (intTx),
		.intRx       (intRx)
	);

	// Commands towards the bus
	i2cFifo #(
		.entry_t    (i2cCmd_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) uCmdFifo (
		.PCLK     (PCLK),
		.PRESETn  (PRESETn),
		.inValid  (cmdValid),
		.inData   (cmdData),
		.inReady  (cmdReady),
		.outValid (cmdOutValid),
		.outData  (cmdOut),
		.outReady (cmdOutReady),
		.empty    (txEmpty),
		.full     ()
	);

	i2cMasterEngine uEngine (
		.PCLK     (PCLK),
		.PRESETn  (PRESETn),
		.clkDiv   (clkDiv),
		.cmdValid (cmdOutValid),
		.cmd      (cmdOut),
		.cmdReady (cmdOutReady),
		.rxValid  (rxValid),
		.rxData   (rxData),
		.rxReady  (rxReady),
		.busy     (engineBusy),
		.sclOe    (sclOe),
		.sdaOe    (sdaOe),
		.sclIn    (sclIn),
		.sdaIn    (sdaIn)
	);

	// Results back to the host
	i2cFifo #(
		.entry_t    (i2cRx_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) uRxFifo (
		.PCLK     (PCLK),
		.PRESETn  (PRESETn),
		.inValid  (rxValid),
		.inData   (rxData),
		.inReady  (rxReady),
		.outValid (rxHeadValid),
		.outData  (rxHead),
		.outReady (rxPopReady),
		.empty    (),
		.full     ()
	);

endmodule

`default_nettype wire

//--- verif/i2cSlaveModel.sv
/*
 * Behavioural I2C target for the testbench.
 * Answers one 7-bit address, stores written bytes from index 0 after each
 * start and returns memory bytes on reads. Unwritten bytes hold index*7+3.
 */
`timescale 1ns/1ps
`default_nettype none

module i2cSlaveModel #(
	parameter logic [6:0] ADDR     = 7'h2A,
	parameter int         MEM_SIZE = 16
) (
	inout wire scl,
	inout wire sda
);

	logic [7:0] mem [MEM_SIZE];
	logic       sdaPull;
	logic       active;
	logic       inAddr;
	logic       sending;
	logic       masterNack;
	logic [3:0] nClk;
	logic [7:0] rxShift;
	logic [7:0] txByte;
	int         ptr;

	// Open drain, only ever pulls low
	assign sda = sdaPull ? 1'b0 : 1'bz;

	initial
	begin
		for (int i = 0; i < MEM_SIZE; i++)
			mem[i] = 8'(i * 7 + 3);
		sdaPull    = 1'b0;
		active     = 1'b0;
		inAddr     = 1'b0;
		sending    = 1'b0;
		masterNack = 1'b0;
		nClk       = '0;
		rxShift    = '0;
		txByte     = '0;
		ptr        = 0;
	end

	////////////////////////////////////////////////////////////////////
	// Start and stop
	////////////////////////////////////////////////////////////////////

	// SDA falling while SCL is high
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			active  = 1'b1;
			inAddr  = 1'b1;
			sending = 1'b0;
			nClk    = '0;
			ptr     = 0;
		end
	end

	// SDA rising while SCL is high
	always @(posedge sda)
	begin
		if (scl === 1'b1)
		begin
			active  = 1'b0;
			sending = 1'b0;
			sdaPull = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Bit clocking, nClk counts SCL rises in the 9-clock frame
	////////////////////////////////////////////////////////////////////

	always @(posedge scl)
	begin
		if (active)
		begin
			if (nClk < 4'd8 && !sending)
				rxShift = {rxShift[6:0], sda};
			// Master ack after a byte we sent, high is nack
			if (nClk == 4'd8 && sending)
				masterNack = sda;
			nClk = nClk + 1'b1;
		end
	end

	// All SDA changes happen just after SCL falls
	always @(negedge scl)
	begin
		if (active)
		begin
			if (nClk == 4'd8)
			begin
				if (inAddr)
				begin
					inAddr = 1'b0;
					if (rxShift[7:1] == ADDR)
					begin
						sending = rxShift[0];
						sdaPull = 1'b1;
					end
					else
						active = 1'b0;
				end
				else if (sending)
					sdaPull = 1'b0;
				else
				begin
					mem[ptr % MEM_SIZE] = rxShift;
					ptr                 = ptr + 1;
					sdaPull             = 1'b1;
				end
			end
			else if (nClk == 4'd9)
			begin
				// Ack slot over, next frame
				nClk    = '0;
				sdaPull = 1'b0;
				if (sending && masterNack)
				begin
					sending = 1'b0;
					active  = 1'b0;
				end
				else if (sending)
				begin
					txByte  = mem[ptr % MEM_SIZE];
					ptr     = ptr + 1;
					sdaPull = !txByte[7];
				end
			end
			else if (sending)
				sdaPull = !txByte[7 - nClk];
		end
	end

endmodule

`default_nettype wire

//--- verif/tbApbI2c.sv
/*
 * Testbench of the APB I2C master with a behavioural target on the bus.
 * Runs reset, write, read, nack and back-pressure tests through APB,
 * checks RX words in a separate process and ends with a summary line.
 */
`timescale 1ns/1ps
`default_nettype none

module tbApbI2c
	import apbRegPkg::*;
();

	localparam int FIFO_DEPTH = 4;
	localparam int DIV_RESET  = 4;
	localparam int MEM_SIZE   = 16;
	localparam logic [6:0] SLAVE_ADDR  = 7'h2A;
	localparam logic [6:0] ABSENT_ADDR = 7'h55;
	// Slowest test: about 5 bytes of 36 quarters at divider 1000, plus margin
	localparam int SLOW_DIV        = 1000;
	localparam int LONG_TEST_BYTES = 5;
	localparam int TIMEOUT_CYCLES  = LONG_TEST_BYTES * 36 * (SLOW_DIV + 1) + 20000;
	localparam logic [31:0] IDLE_STAT = (1 << STAT_TX_EMPTY) | (1 << STAT_RX_EMPTY);
	localparam logic [31:0] ACK_MASK  = 1 << RX_ACK_BIT;

	logic        PCLK;
	logic        PRESETn;
	logic        PSEL;
	logic        PENABLE;
	logic        PWRITE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic        PREADY;
	logic        PSLVERR;
	logic        intTx;
	logic        intRx;
	logic        sclOe;
	logic        sdaOe;
	wire         scl;
	wire         sda;

	string       testName;
	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;
	logic [31:0] expWordQ [$];
	logic [31:0] expMaskQ [$];
	logic [31:0] expWord;
	logic [31:0] expMask;
	logic [7:0]  refMem [MEM_SIZE];
	logic        refWritten [MEM_SIZE];
	logic [7:0]  wrBytes [3];
	logic [31:0] rdData;
	logic        slvErr;

	// Open-drain bus with pull-ups
	pullup (scl);
	pullup (sda);
	assign scl = sclOe ? 1'b0 : 1'bz;
	assign sda = sdaOe ? 1'b0 : 1'bz;

	apbI2cTop #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.DIV_RESET  (DIV_RESET)
	) u_dut (
		.PCLK    (PCLK),
		.PRESETn (PRESETn),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.PRDATA  (PRDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR),
		.intTx   (intTx),
		.intRx   (intRx),
		.sclOe   (sclOe),
		.sdaOe   (sdaOe),
		.sclIn   (scl),
		.sdaIn   (sda)
	);

	i2cSlaveModel #(
		.ADDR     (SLAVE_ADDR),
		.MEM_SIZE (MEM_SIZE)
	) u_slave (
		.scl (scl),
		.sda (sda)
	);

	initial
	begin
		PCLK = 1'b0;
		forever #4 PCLK = ~PCLK;
	end

	// Hang guard
	always @(posedge PCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("ERROR: run stopped after %0d cycles, a wait never ended", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Reference model, compare and APB tasks
	////////////////////////////////////////////////////////////////////////

	// Byte the target holds at an index, last write wins over the preset
	function automatic logic [7:0] refByte(input int idx);
		if (refWritten[idx % MEM_SIZE])
			return refMem[idx % MEM_SIZE];
		return 8'(idx * 7 + 3);
	endfunction

	function automatic logic [31:0] cmdWord(input logic start, input logic stop,
		input logic read, input logic ackOut, input logic [7:0] data);
		logic [31:0] w;
		w                             = '0;
		w[CMD_DATA_MSB:CMD_DATA_LSB]  = data;
		w[CMD_READ_BIT]               = read;
		w[CMD_START_BIT]              = start;
		w[CMD_STOP_BIT]               = stop;
		w[CMD_ACKOUT_BIT]             = ackOut;
		return w;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data,
		output logic err);
		@(negedge PCLK);
		PSEL    = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = 1'b1;
		PADDR   = addr;
		PWDATA  = data;
		@(negedge PCLK);
		PENABLE = 1'b1;
		@(posedge PCLK);
		err = PSLVERR;
		compareValue({testName, " write PREADY"}, 1, PREADY);
		@(negedge PCLK);
		PSEL    = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] data,
		output logic err);
		@(negedge PCLK);
		PSEL    = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = 1'b0;
		PADDR   = addr;
		@(negedge PCLK);
		PENABLE = 1'b1;
		// Sampled before the access edge pops anything
		@(posedge PCLK);
		data = PRDATA;
		err  = PSLVERR;
		compareValue({testName, " read PREADY"}, 1, PREADY);
		@(negedge PCLK);
		PSEL    = 1'b0;
		PENABLE = 1'b0;
	endtask

	// Queue one command, it must be accepted
	task automatic sendCmd(input logic [31:0] word);
		logic err;
		apbWrite(ADDR_TX, word, err);
		compareValue({testName, " TX PSLVERR"}, 0, err);
	endtask

	// Wait for a result and pop it, the checker compares the masked word
	task automatic popRx(input logic [31:0] expected, input logic [31:0] mask);
		logic [31:0] data;
		logic        err;
		while (!intRx)
			@(negedge PCLK);
		expWordQ.push_back(expected);
		expMaskQ.push_back(mask);
		apbRead(ADDR_RX, data, err);
	endtask

	task automatic waitTxDone();
		while (!intTx)
			@(negedge PCLK);
	endtask

	task automatic checkStatus(input string name, input logic [31:0] expected);
		logic [31:0] data;
		logic        err;
		apbRead(ADDR_STAT, data, err);
		compareValue(name, expected, data);
	endtask

	// RX checker, every successful pop is matched against the queue head
	always @(posedge PCLK)
	begin
		if (PSEL && PENABLE && !PWRITE && PADDR == ADDR_RX && !PSLVERR)
		begin
			if (expWordQ.size() == 0)
			begin
				errorCount++;
				$display("ERROR: RX word 0x%0h was popped with nothing expected", PRDATA);
			end
			else
			begin
				expWord = expWordQ.pop_front();
				expMask = expMaskQ.pop_front();
				compareValue({testName, " RX word"}, expWord & expMask, PRDATA & expMask);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////

	initial
	begin
		PRESETn = 1'b0;
		PSEL    = 1'b0;
		PENABLE = 1'b0;
		PWRITE  = 1'b0;
		PADDR   = '0;
		PWDATA  = '0;
		testName = "reset";
		void'($urandom(31));
		for (int i = 0; i < MEM_SIZE; i++)
		begin
			refMem[i]     = '0;
			refWritten[i] = 1'b0;
		end
		repeat (2)
			@(posedge PCLK);
		@(negedge PCLK);
		PRESETn = 1'b1;

		// Reset values and divider read-back
		@(negedge PCLK);
		compareValue("reset intTx", 1, intTx);
		compareValue("reset intRx", 0, intRx);
		compareValue("reset sclOe", 0, sclOe);
		compareValue("reset sdaOe", 0, sdaOe);
		checkStatus("reset status", IDLE_STAT);
		apbRead(ADDR_CFG, rdData, slvErr);
		compareValue("reset divider", DIV_RESET, rdData);
		apbWrite(ADDR_CFG, 7, slvErr);
		apbRead(ADDR_CFG, rdData, slvErr);
		compareValue("divider read-back", 7, rdData);
		apbWrite(ADDR_CFG, DIV_RESET, slvErr);

		// Address then three random bytes into the target
		testName = "write transaction";
		for (int i = 0; i < 3; i++)
			wrBytes[i] = 8'($urandom_range(255, 0));
		sendCmd(cmdWord(1'b1, 1'b0, 1'b0, 1'b0, {SLAVE_ADDR, 1'b0}));
		for (int i = 0; i < 3; i++)
			sendCmd(cmdWord(1'b0, i == 2, 1'b0, 1'b0, wrBytes[i]));
		for (int i = 0; i < 4; i++)
			popRx(0, ACK_MASK);
		waitTxDone();
		for (int i = 0; i < 3; i++)
		begin
			refMem[i]     = wrBytes[i];
			refWritten[i] = 1'b1;
			compareValue("target memory", wrBytes[i], u_slave.mem[i]);
		end

		// Four reads, the last one nacked with stop
		testName = "read transaction";
		sendCmd(cmdWord(1'b1, 1'b0, 1'b0, 1'b0, {SLAVE_ADDR, 1'b1}));
		for (int i = 0; i < 4; i++)
			sendCmd(cmdWord(1'b0, i == 3, 1'b1, i == 3, 8'h00));
		popRx(0, ACK_MASK);
		for (int i = 0; i < 4; i++)
			popRx(refByte(i), 32'hFF);
		waitTxDone();

		// Nobody answers, sticky ack error until STAT is written
		testName = "absent target";
		sendCmd(cmdWord(1'b1, 1'b1, 1'b0, 1'b0, {ABSENT_ADDR, 1'b0}));
		popRx(ACK_MASK, ACK_MASK);
		waitTxDone();
		checkStatus("ack error set", IDLE_STAT | (1 << STAT_ACK_ERR));
		apbWrite(ADDR_STAT, 0, slvErr);
		checkStatus("ack error cleared", IDLE_STAT);

		// Slow bus so the command FIFO fills behind the first command
		testName = "back-pressure";
		apbWrite(ADDR_CFG, SLOW_DIV, slvErr);
		for (int i = 0; i <= FIFO_DEPTH; i++)
			sendCmd(cmdWord(1'b1, 1'b1, 1'b0, 1'b0, {ABSENT_ADDR, 1'b0}));
		apbRead(ADDR_STAT, rdData, slvErr);
		compareValue("full and busy", (1 << STAT_TX_FULL) | (1 << STAT_BUSY),
			rdData & ((1 << STAT_TX_FULL) | (1 << STAT_BUSY)));
		apbWrite(ADDR_TX, cmdWord(1'b1, 1'b1, 1'b0, 1'b0, {ABSENT_ADDR, 1'b0}), slvErr);
		compareValue("TX write when full PSLVERR", 1, slvErr);
		apbRead(ADDR_RX, rdData, slvErr);
		compareValue("RX read when empty PSLVERR", 1, slvErr);
		compareValue("RX read when empty data", 0, rdData);
		// Speed up to drain
		apbWrite(ADDR_CFG, DIV_RESET, slvErr);
		for (int i = 0; i <= FIFO_DEPTH; i++)
			popRx(ACK_MASK, ACK_MASK);
		waitTxDone();
		apbWrite(ADDR_STAT, 0, slvErr);
		checkStatus("final status", IDLE_STAT);

		if (expWordQ.size() != 0)
		begin
			errorCount++;
			$display("ERROR: %0d expected RX words were never popped", expWordQ.size());
		end
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
design/apbRegPkg.sv
design/i2cPkg.sv
design/i2cFifo.sv
design/apbI2cRegs.sv
design/i2cMasterEngine.sv
design/apbI2cTop.sv
verif/i2cSlaveModel.sv
verif/tbApbI2c.sv

//--- Bender.yml
package:
  name: apb_i2c

sources:
  # Packages first, then the RTL bottom up
  - files:
      - design/apbRegPkg.sv
      - design/i2cPkg.sv
      - design/i2cFifo.sv
      - design/apbI2cRegs.sv
      - design/i2cMasterEngine.sv
      - design/apbI2cTop.sv

  - target: test
    files:
      - verif/i2cSlaveModel.sv
      - verif/tbApbI2c.sv
